// File: nic_macros.svh
`ifndef NIC_MACROS_SVH
`define NIC_MACROS_SVH

// Switch geometry
`define NIC_NUM_PORTS   4
`define NIC_DATA_WID    32

// Entries per input buffer
`define NIC_FIFO_DEPTH  16

// Raw destination field on the input side, only the low bits route
`define NIC_DEST_WID    4

`endif

// File: nic_port_pkg.sv
`default_nettype none

`include "nic_macros.svh"

package nic_port_pkg;

    // ==================================================
    // Port addressing
    // ==================================================

    // Index of one switch port
    typedef logic [$clog2(`NIC_NUM_PORTS)-1:0] port_t;

    // Routing info that rides along with every beat
    typedef struct packed {
        port_t src;
        port_t dest;
    } route_meta_t;

endpackage : nic_port_pkg

`default_nettype wire

// File: nic_stream_pkg.sv
`default_nettype none

`include "nic_macros.svh"

package nic_stream_pkg;

    // ==================================================
    // Stream beats
    // ==================================================

    // Raw beat as seen on an input port
    typedef struct packed {
        logic [`NIC_DATA_WID-1:0] data;
        logic                     last;
    } beat_t;

    // Beat inside the switch, tagged with its route
    typedef struct packed {
        beat_t                     beat;
        nic_port_pkg::route_meta_t meta;
    } tagged_beat_t;

    // Beat leaving an output, with id and user metadata
    typedef struct packed {
        beat_t               beat;
        nic_port_pkg::port_t id;
        nic_port_pkg::port_t user;
    } egress_beat_t;

endpackage : nic_stream_pkg

`default_nettype wire

// File: beat_fifo.sv
`timescale 1ns/1ns
`default_nettype none

`include "nic_macros.svh"

module beat_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = `NIC_FIFO_DEPTH
) (
    input  logic     axis_clk,
    input  logic     reset,
    input  logic     wr_valid,
    input  payload_t wr_data,
    input  logic     rd_pop,
    output payload_t rd_data,
    output logic     rd_ready
);
    localparam int PTR_WID = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t           mem [DEPTH];
    logic [PTR_WID-1:0] wr_ptr;
    logic [PTR_WID-1:0] rd_ptr;
    logic [PTR_WID:0]   count;
    logic               do_pop;

    // Pointer step with wrap for any depth
    function automatic logic [PTR_WID-1:0] next_ptr(input logic [PTR_WID-1:0] ptr);
        return (ptr == PTR_WID'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Head is visible without a pop
    assign rd_ready = (count != '0);
    assign rd_data  = mem[rd_ptr];
    assign do_pop   = rd_pop && rd_ready;

    always_ff @(posedge axis_clk) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_valid) wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)   rd_ptr <= next_ptr(rd_ptr);
            case ({wr_valid, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule : beat_fifo

`default_nettype wire

// File: ingress_port.sv
`timescale 1ns/1ns
`default_nettype none

`include "nic_macros.svh"

module ingress_port #(
    parameter nic_port_pkg::port_t SRC_PORT = '0
) (
    input  logic                         axis_clk,
    input  logic                         reset,
    input  logic                         in_valid,
    input  nic_stream_pkg::beat_t        in_beat,
    input  logic [`NIC_DEST_WID-1:0]     in_dest,
    output logic                         tag_valid,
    output nic_stream_pkg::tagged_beat_t tag_beat
);
    import nic_port_pkg::*;

    logic  sop;
    port_t dest_hold;
    port_t dest_cur;

    // Only the low bits of the raw destination select a port
    assign dest_cur = sop ? port_t'(in_dest) : dest_hold;

    // Packet start tracking, next beat after last is a new packet
    always_ff @(posedge axis_clk) begin
        if (reset) begin
            sop       <= 1'b1;
            dest_hold <= '0;
        end else if (in_valid) begin
            sop       <= in_beat.last;
            dest_hold <= dest_cur;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (reset) begin
            tag_valid <= 1'b0;
        end else begin
            tag_valid <= in_valid;
        end
    end

    // Tagged beat register
    always_ff @(posedge axis_clk) begin
        if (in_valid) begin
            tag_beat.beat      <= in_beat;
            tag_beat.meta.src  <= SRC_PORT;
            tag_beat.meta.dest <= dest_cur;
        end
    end

endmodule : ingress_port

`default_nettype wire

// File: switch_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "nic_macros.svh"

module switch_core (
    input  logic                         axis_clk,
    input  logic                         reset,
    input  logic [`NIC_NUM_PORTS-1:0]    tag_valid,
    input  nic_stream_pkg::tagged_beat_t tag_beat [`NIC_NUM_PORTS],
    output logic [`NIC_NUM_PORTS-1:0]    sw_valid,
    output nic_stream_pkg::tagged_beat_t sw_beat  [`NIC_NUM_PORTS]
);
    import nic_port_pkg::*;
    import nic_stream_pkg::*;

    localparam int NP = `NIC_NUM_PORTS;

    // ==================================================
    // Input buffering
    // ==================================================

    tagged_beat_t      head     [NP];
    logic [NP-1:0]     head_rdy;
    logic [NP-1:0]     pop;

    for (genvar i = 0; i < NP; i++) begin : g_in_fifo
        beat_fifo #(
            .payload_t (tagged_beat_t),
            .DEPTH     (`NIC_FIFO_DEPTH)
        ) i_beat_fifo (
            .axis_clk (axis_clk),
            .reset    (reset),
            .wr_valid (tag_valid[i]),
            .wr_data  (tag_beat[i]),
            .rd_pop   (pop[i]),
            .rd_data  (head[i]),
            .rd_ready (head_rdy[i])
        );
    end

    // ==================================================
    // Per-output arbitration
    // ==================================================

    // Per-output state
    port_t         grant_src [NP];
    logic [NP-1:0] busy;
    port_t         rr_ptr    [NP];

    // Requests indexed [input][output]
    logic [NP-1:0] req [NP];
    port_t         sel_src [NP];
    logic [NP-1:0] sel_vld;

    // An idle input's head is always a first beat, so a match on dest is a request
    always_comb begin
        for (int i = 0; i < NP; i++) begin
            for (int o = 0; o < NP; o++) begin
                req[i][o] = head_rdy[i] && (head[i].meta.dest == port_t'(o));
            end
        end
    end

    always_comb begin
        port_t cand;
        cand = '0;
        for (int o = 0; o < NP; o++) begin
            // Busy output keeps draining its granted input
            sel_src[o] = grant_src[o];
            sel_vld[o] = busy[o] && head_rdy[grant_src[o]];
            if (!busy[o]) begin
                // Walk downward so the input right after the last winner ends up on top
                for (int k = NP; k >= 1; k--) begin
                    cand = rr_ptr[o] + port_t'(k);
                    if (req[cand][o]) begin
                        sel_src[o] = cand;
                        sel_vld[o] = 1'b1;
                    end
                end
            end
        end
    end

    // One pop per input, its head has a single destination
    always_comb begin
        pop = '0;
        for (int o = 0; o < NP; o++) begin
            if (sel_vld[o]) pop[sel_src[o]] = 1'b1;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (reset) begin
            busy     <= '0;
            sw_valid <= '0;
            for (int o = 0; o < NP; o++) begin
                grant_src[o] <= '0;
                rr_ptr[o]    <= port_t'(NP - 1);
            end
        end else begin
            sw_valid <= sel_vld;
            for (int o = 0; o < NP; o++) begin
                if (sel_vld[o]) begin
                    // Grant released on the last beat of the packet
                    busy[o]      <= !head[sel_src[o]].beat.last;
                    grant_src[o] <= sel_src[o];
                end
                if (sel_vld[o] && !busy[o]) rr_ptr[o] <= sel_src[o];
            end
        end
    end

    // Output beat register
    always_ff @(posedge axis_clk) begin
        for (int o = 0; o < NP; o++) begin
            if (sel_vld[o]) sw_beat[o] <= head[sel_src[o]];
        end
    end

endmodule : switch_core

`default_nettype wire

// File: egress_port.sv
`timescale 1ns/1ns
`default_nettype none

module egress_port #(
    parameter bit HOST_PORT = 1'b0
) (
    input  logic                         axis_clk,
    input  logic                         reset,
    input  logic                         sw_valid,
    input  nic_stream_pkg::tagged_beat_t sw_beat,
    output logic                         out_valid,
    output nic_stream_pkg::egress_beat_t out_beat
);
    import nic_stream_pkg::*;

    egress_beat_t egr_beat;
    logic         out_rdy;

    // Wire ports carry no user info, host ports see the source port
    always_comb begin
        egr_beat.beat = sw_beat.beat;
        egr_beat.id   = sw_beat.meta.src;
        egr_beat.user = HOST_PORT ? sw_beat.meta.src : '0;
    end

    // Two-entry stage, drained as soon as something lands
    beat_fifo #(
        .payload_t (egress_beat_t),
        .DEPTH     (2)
    ) i_beat_fifo (
        .axis_clk (axis_clk),
        .reset    (reset),
        .wr_valid (sw_valid),
        .wr_data  (egr_beat),
        .rd_pop   (out_rdy),
        .rd_data  (out_beat),
        .rd_ready (out_rdy)
    );

    assign out_valid = out_rdy;

endmodule : egress_port

`default_nettype wire

// File: nic_switch_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "nic_macros.svh"

module nic_switch_top (
    input  logic                         axis_clk,
    input  logic                         reset,
    input  logic [`NIC_NUM_PORTS-1:0]    in_valid,
    input  nic_stream_pkg::beat_t        in_beat  [`NIC_NUM_PORTS],
    input  logic [`NIC_DEST_WID-1:0]     in_dest  [`NIC_NUM_PORTS],
    output logic [`NIC_NUM_PORTS-1:0]    out_valid,
    output nic_stream_pkg::egress_beat_t out_beat [`NIC_NUM_PORTS]
);
    import nic_port_pkg::*;
    import nic_stream_pkg::*;

    logic [`NIC_NUM_PORTS-1:0] tag_valid;
    tagged_beat_t              tag_beat [`NIC_NUM_PORTS];
    logic [`NIC_NUM_PORTS-1:0] sw_valid;
    tagged_beat_t              sw_beat  [`NIC_NUM_PORTS];

    // ==================================================
    // Input side
    // ==================================================
    for (genvar i = 0; i < `NIC_NUM_PORTS; i++) begin : g_ingress
        ingress_port #(
            .SRC_PORT (port_t'(i))
        ) i_ingress_port (
            .axis_clk  (axis_clk),
            .reset     (reset),
            .in_valid  (in_valid[i]),
            .in_beat   (in_beat[i]),
            .in_dest   (in_dest[i]),
            .tag_valid (tag_valid[i]),
            .tag_beat  (tag_beat[i])
        );
    end

    switch_core i_switch_core (
        .axis_clk  (axis_clk),
        .reset     (reset),
        .tag_valid (tag_valid),
        .tag_beat  (tag_beat),
        .sw_valid  (sw_valid),
        .sw_beat   (sw_beat)
    );

    // ==================================================
    // Output side, lower half wire, upper half host
    // ==================================================
    for (genvar i = 0; i < `NIC_NUM_PORTS; i++) begin : g_egress
        egress_port #(
            .HOST_PORT (i >= `NIC_NUM_PORTS / 2)
        ) i_egress_port (
            .axis_clk  (axis_clk),
            .reset     (reset),
            .sw_valid  (sw_valid[i]),
            .sw_beat   (sw_beat[i]),
            .out_valid (out_valid[i]),
            .out_beat  (out_beat[i])
        );
    end

endmodule : nic_switch_top

`default_nettype wire

// File: tb_nic_switch.sv
`timescale 1ns/1ns
`default_nettype none

`include "nic_macros.svh"

module tb_nic_switch;
    import nic_port_pkg::*;
    import nic_stream_pkg::*;

    localparam int NP        = `NIC_NUM_PORTS;
    localparam int COLS      = 5;
    localparam int MAX_BEATS = 64;

    logic                      clk;
    logic                      reset;
    logic [NP-1:0]             in_valid;
    beat_t                     in_beat  [NP];
    logic [`NIC_DEST_WID-1:0]  in_dest  [NP];
    logic [NP-1:0]             out_valid;
    egress_beat_t              out_beat [NP];

    logic [31:0]  td_mem [0:COLS*MAX_BEATS-1];
    egress_beat_t exp_q [NP*NP][$];
    int           port_lines [NP][$];
    int           test_list[$];
    logic [NP-1:0] sop_q;
    port_t        dest_q [NP];
    logic [NP-1:0] pkt_open;
    port_t        pkt_src [NP];

    int num_beats = 0;
    int cycle_cnt = 0;
    int cycle_limit = 0;
    int cur_test = 0;
    int test_errs = 0;
    int test_checks = 0;
    int err_total = 0;
    int tests_run = 0;
    int tests_failed = 0;

    nic_switch_top i_nic_switch_top (
        .axis_clk  (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_beat   (in_beat),
        .in_dest   (in_dest),
        .out_valid (out_valid),
        .out_beat  (out_beat)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic string test_name(input int tid);
        case (tid)
            1:       return "single_packets";
            2:       return "contention";
            3:       return "dest_truncation";
            4:       return "metadata";
            5:       return "completeness";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        test_checks++;
        if (exp !== act) begin
            $display("FAIL %s: %s expected %h, actual %h", test_name(cur_test), what, exp, act);
            test_errs++;
            err_total++;
        end
    endtask

    function automatic bit queues_empty();
        for (int i = 0; i < NP * NP; i++) begin
            if (exp_q[i].size() != 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    // Drive one beat and predict what the switch delivers for it
    task automatic drive_beat(input int p, input int li);
        egress_beat_t exp_beat;
        logic [31:0]  raw;
        port_t        out;
        raw = td_mem[li*COLS + 2];
        in_valid[p]      = 1'b1;
        in_beat[p].data  = td_mem[li*COLS + 3];
        in_beat[p].last  = td_mem[li*COLS + 4][0];
        in_dest[p]       = raw[`NIC_DEST_WID-1:0];
        // Only the first beat of a packet picks the output
        if (sop_q[p]) dest_q[p] = port_t'(raw);
        sop_q[p] = in_beat[p].last;
        out = dest_q[p];
        exp_beat.beat = in_beat[p];
        exp_beat.id   = port_t'(p);
        exp_beat.user = (int'(out) >= NP / 2) ? port_t'(p) : '0;
        exp_q[int'(out)*NP + p].push_back(exp_beat);
    endtask

    task automatic report_test();
        tests_run++;
        if (test_errs != 0) tests_failed++;
        $display("[test %0d %s] %s, %0d checks, %0d errors", cur_test, test_name(cur_test),
                 (test_errs == 0) ? "ok" : "errors", test_checks, test_errs);
    endtask

    task automatic run_test(input int tid);
        int n_cyc;
        n_cyc = 0;
        cur_test = tid;
        test_errs = 0;
        test_checks = 0;
        for (int p = 0; p < NP; p++) port_lines[p].delete();
        for (int li = 0; li < num_beats; li++) begin
            if (int'(td_mem[li*COLS]) == tid) begin
                port_lines[int'(td_mem[li*COLS + 1]) % NP].push_back(li);
            end
        end
        for (int p = 0; p < NP; p++) begin
            if (port_lines[p].size() > n_cyc) n_cyc = port_lines[p].size();
        end
        // The k-th beat of every input goes out in the same cycle
        for (int k = 0; k < n_cyc; k++) begin
            @(posedge clk);
            #1;
            for (int p = 0; p < NP; p++) begin
                if (k < port_lines[p].size()) drive_beat(p, port_lines[p][k]);
                else in_valid[p] = 1'b0;
            end
        end
        @(posedge clk);
        #1;
        in_valid = '0;
        while (!queues_empty()) @(posedge clk);
        report_test();
    endtask

    // ==================================================
    // Output monitor
    // ==================================================
    always @(negedge clk) begin
        egress_beat_t exp_beat;
        int           idx;
        if (!reset) begin
            for (int o = 0; o < NP; o++) begin
                if (out_valid[o]) begin
                    idx = o*NP + int'(out_beat[o].id);
                    if (pkt_open[o]) begin
                        check_value($sformatf("source on output %0d", o),
                                    64'(pkt_src[o]), 64'(out_beat[o].id));
                    end
                    pkt_open[o] = !out_beat[o].beat.last;
                    pkt_src[o]  = out_beat[o].id;
                    if (exp_q[idx].size() == 0) begin
                        $display("Unexpected beat on output %0d from source %0d in test %s",
                                 o, out_beat[o].id, test_name(cur_test));
                        test_errs++;
                        err_total++;
                    end else begin
                        exp_beat = exp_q[idx].pop_front();
                        check_value($sformatf("beat on output %0d", o),
                                    64'(exp_beat), 64'(out_beat[o]));
                    end
                end
            end
        end
    end

    // Run limit scaled to the number of beats in the data
    initial begin
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles, expected beats never arrived", cycle_limit);
        // Name every output stream that is still short
        for (int i = 0; i < NP * NP; i++) begin
            if (exp_q[i].size() != 0) begin
                $display("Output %0d still misses %0d beats from source %0d",
                         i / NP, exp_q[i].size(), i % NP);
            end
        end
        $display("Test failures found");
        $finish;
    end

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        reset    = 1'b1;
        in_valid = '0;
        sop_q    = '1;
        pkt_open = '0;
        for (int p = 0; p < NP; p++) begin
            in_beat[p] = '0;
            in_dest[p] = '0;
            dest_q[p]  = '0;
            pkt_src[p] = '0;
        end
        $readmemh("nic_testdata.txt", td_mem);
        while (num_beats < MAX_BEATS && td_mem[num_beats*COLS] != 32'h0) begin
            if (test_list.size() == 0 || test_list[$] != int'(td_mem[num_beats*COLS])) begin
                test_list.push_back(int'(td_mem[num_beats*COLS]));
            end
            num_beats++;
        end
        cycle_limit = 20 * num_beats + 200;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        foreach (test_list[t]) run_test(test_list[t]);

        // Quiet period to catch stray beats after the drain
        cur_test = 5;
        test_errs = 0;
        test_checks = 0;
        repeat (10) @(posedge clk);
        report_test();

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_total);
        if (err_total == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : tb_nic_switch

`default_nettype wire

// File: sim.f
+incdir+.
nic_port_pkg.sv
nic_stream_pkg.sv
beat_fifo.sv
ingress_port.sv
switch_core.sv
egress_port.sv
nic_switch_top.sv
tb_nic_switch.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0
TOP       := tb_nic_switch
FILELIST  := sim.f
BUILD_DIR := obj_dir
LOG       := sim.log
SOURCES   := $(wildcard *.sv) $(wildcard *.svh)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: nic_testdata.txt
// Columns: test id, input port, raw destination, data, last
// A line with test id 0 ends the data
01 0 3 a0000001 0
01 0 3 a0000002 1
01 1 2 b0000001 1
01 2 1 c0000001 0
01 2 1 c0000002 1
01 3 0 d0000001 1
02 0 2 a1000001 0
02 0 2 a1000002 0
02 0 2 a1000003 1
02 1 2 b1000001 0
02 1 2 b1000002 0
02 1 2 b1000003 1
02 3 2 d1000001 1
03 3 d d2000001 0
03 3 2 d2000002 0
03 3 0 d2000003 1
03 1 8 b2000001 0
03 1 7 b2000002 1
04 0 2 a3000001 1
04 1 3 b3000001 1
04 2 0 c3000001 1
04 3 1 d3000001 1
00 0 0 00000000 0
